//--- wb_copy.f
hw/wb_copy_pkg.sv
hw/sp_ram.sv
hw/wb_ram_slave.sv
hw/wb_decoder.sv
hw/copy_sum.sv
hw/copy_ctrl.sv
hw/wb_copy_top.sv
dv/tb_wb_copy.sv

//--- Bender.yml
package:
  name: wb_copy

sources:
  - hw/wb_copy_pkg.sv
  - hw/sp_ram.sv
  - hw/wb_ram_slave.sv
  - hw/wb_decoder.sv
  - hw/copy_sum.sv
  - hw/copy_ctrl.sv
  - hw/wb_copy_top.sv
  - target: test
    files:
      - dv/tb_wb_copy.sv

//--- dv/wb_copy_testdata.txt
// columns are op src dst len data expected_rdata stray in hex
// op is 0 write 1 read 2 copy 3 fill or f for the end, stray 1 strobes a write of data to src
0 000 005 001 11112222 00000000 0
1 005 000 001 00000000 11112222 0
0 000 1A0 001 33334444 11112222 0
1 1A0 000 001 00000000 33334444 0
0 000 180 001 CAFEF00D 33334444 0
3 180 080 100 01000001 00000100 1
1 080 000 001 00000000 01000001 0
1 17F 000 001 00000000 01000001 0
1 180 000 001 00000000 CAFEF00D 0
0 000 010 001 00000101 CAFEF00D 0
0 000 011 001 00000202 CAFEF00D 0
0 000 012 001 80000000 CAFEF00D 0
2 010 110 003 00000000 80000303 0
1 112 000 001 00000000 80000000 0
2 111 030 002 00000000 80000202 0
1 030 000 001 00000000 00000202 0
1 031 000 001 00000000 80000000 0
2 005 1F0 001 0BADBEEF 11112222 1
1 1F0 000 001 00000000 11112222 0
1 005 000 001 00000000 11112222 0
f 000 000 000 00000000 00000000 0

//--- dv/tb_wb_copy.sv
`timescale 1ns/1ps

module tb_wb_copy;
    import wb_copy_pkg::*;

    // words per record in the data file
    localparam int REC_W   = 7;
    localparam int MAX_REC = 64;

    logic              clk;
    logic              reset;
    logic              cmd_valid_i;
    copy_op_e          cmd_op_i;
    logic [ADDR_W-1:0] cmd_src_i;
    logic [ADDR_W-1:0] cmd_dst_i;
    logic [LEN_W-1:0]  cmd_len_i;
    logic [DATA_W-1:0] cmd_data_i;
    logic              busy_o;
    logic              done_o;
    logic [DATA_W-1:0] rdata_o;

    // raw words from the data file
    logic [31:0] td [0:REC_W*MAX_REC-1];
    // xorshift state for idle gaps
    logic [31:0] rnd;
    int          cycles;
    int          limit;
    int          n_rec;

    wb_copy_top u_dut (
        .clk         (clk),
        .reset       (reset),
        .cmd_valid_i (cmd_valid_i),
        .cmd_op_i    (cmd_op_i),
        .cmd_src_i   (cmd_src_i),
        .cmd_dst_i   (cmd_dst_i),
        .cmd_len_i   (cmd_len_i),
        .cmd_data_i  (cmd_data_i),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .rdata_o     (rdata_o)
    );

    // 4 ns clock
    always #2 clk = ~clk;

    // run length guard
    always @(posedge clk) begin
        if (limit != 0 && cycles > limit) begin
            $display("timeout after %0d cycles, a command never signalled done", cycles);
            $display("CHECKS FAILED");
            $fatal(1);
        end else begin
            cycles <= cycles + 1;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic string op_name(input logic [3:0] op);
        case (op)
            4'h0: return "write";
            4'h1: return "read";
            4'h2: return "copy";
            4'h3: return "fill";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    // strobe one record, wait for done and check the result
    task automatic run_command(input int idx);
        logic [31:0] op;
        logic [31:0] src;
        logic [31:0] dst;
        logic [31:0] len;
        logic [31:0] data;
        logic [31:0] exp;
        logic [31:0] stray;
        int          base;
        string       name;
        base  = idx * REC_W;
        op    = td[base];
        src   = td[base+1];
        dst   = td[base+2];
        len   = td[base+3];
        data  = td[base+4];
        exp   = td[base+5];
        stray = td[base+6];
        name  = $sformatf("cmd%0d_%s", idx, op_name(op[3:0]));
        @(posedge clk);
        cmd_valid_i <= 1'b1;
        cmd_op_i    <= copy_op_e'(op[1:0]);
        cmd_src_i   <= src[ADDR_W-1:0];
        cmd_dst_i   <= dst[ADDR_W-1:0];
        cmd_len_i   <= len[LEN_W-1:0];
        cmd_data_i  <= data;
        // command is taken on this edge
        @(posedge clk);
        if (stray[0]) begin
            // second strobe while busy is a write to src that must be dropped
            cmd_op_i   <= OP_WRITE;
            cmd_dst_i  <= src[ADDR_W-1:0];
            cmd_data_i <= data;
        end else begin
            cmd_valid_i <= 1'b0;
        end
        @(posedge clk);
        cmd_valid_i <= 1'b0;
        check_value({name, "_busy"}, 32'd1, {31'd0, busy_o});
        while (!done_o) begin
            @(posedge clk);
        end
        check_value({name, "_rdata"}, exp, rdata_o);
        // busy drops together with the done pulse
        check_value({name, "_busy_at_done"}, 32'd0, {31'd0, busy_o});
    endtask

    initial begin : stimulus
        int gap;
        clk         = 1'b0;
        reset       = 1'b1;
        cmd_valid_i = 1'b0;
        cmd_op_i    = OP_WRITE;
        cmd_src_i   = '0;
        cmd_dst_i   = '0;
        cmd_len_i   = '0;
        cmd_data_i  = '0;
        cycles      = 0;
        limit       = 0;
        rnd         = 32'h7792;
        $readmemh("dv/wb_copy_testdata.txt", td);
        if ($isunknown(td[0])) begin
            $display("could not read test data from dv/wb_copy_testdata.txt");
            $display("CHECKS FAILED");
            $fatal(1);
        end
        // count records and size the cycle budget
        n_rec = 0;
        limit = 20;
        while (n_rec < MAX_REC && td[n_rec*REC_W] != 32'hf) begin
            limit += 20;
            if (td[n_rec*REC_W] == 32'h2 || td[n_rec*REC_W] == 32'h3) begin
                limit += 4 * int'(td[n_rec*REC_W+3]);
            end
            n_rec++;
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_value("reset_busy", 32'd0, {31'd0, busy_o});
        check_value("reset_done", 32'd0, {31'd0, done_o});
        check_value("reset_rdata", 32'd0, rdata_o);
        for (int i = 0; i < n_rec; i++) begin
            // 0 to 3 idle cycles before each command
            rnd = xorshift32(rnd);
            gap = int'(rnd[1:0]);
            repeat (gap) @(posedge clk);
            run_command(i);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- hw/wb_copy_top.sv
`timescale 1ns/1ps

module wb_copy_top (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           cmd_valid_i,
    input  wb_copy_pkg::copy_op_e          cmd_op_i,
    input  logic [wb_copy_pkg::ADDR_W-1:0] cmd_src_i,
    input  logic [wb_copy_pkg::ADDR_W-1:0] cmd_dst_i,
    input  logic [wb_copy_pkg::LEN_W-1:0]  cmd_len_i,
    input  logic [wb_copy_pkg::DATA_W-1:0] cmd_data_i,
    output logic                           busy_o,
    output logic                           done_o,
    output logic [wb_copy_pkg::DATA_W-1:0] rdata_o
);
    import wb_copy_pkg::*;

    // master side of the bus
    logic [ADDR_W-1:0] m_adr;
    logic [DATA_W-1:0] m_dat_w;
    logic [DATA_W-1:0] m_dat_r;
    logic              m_we;
    logic              m_stb;
    logic              m_cyc;
    logic              m_ack;
    logic [TAG_W-1:0]  m_tag;
    // slave side, after the decoder
    logic              s0_stb;
    logic              s0_cyc;
    logic              s0_ack;
    logic [DATA_W-1:0] s0_dat;
    logic              s1_stb;
    logic              s1_cyc;
    logic              s1_ack;
    logic [DATA_W-1:0] s1_dat;
    // running sum
    logic              sum_clr;
    logic              sum_add;
    logic [DATA_W-1:0] sum_dat;
    logic [DATA_W-1:0] sum;

    copy_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .cmd_valid_i (cmd_valid_i),
        .cmd_op_i    (cmd_op_i),
        .cmd_src_i   (cmd_src_i),
        .cmd_dst_i   (cmd_dst_i),
        .cmd_len_i   (cmd_len_i),
        .cmd_data_i  (cmd_data_i),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .rdata_o     (rdata_o),
        .m_adr_o     (m_adr),
        .m_dat_o     (m_dat_w),
        .m_we_o      (m_we),
        .m_stb_o     (m_stb),
        .m_cyc_o     (m_cyc),
        .m_tag_o     (m_tag),
        .m_dat_i     (m_dat_r),
        .m_ack_i     (m_ack),
        .sum_clr_o   (sum_clr),
        .sum_add_o   (sum_add),
        .sum_dat_o   (sum_dat),
        .sum_i       (sum)
    );

    wb_decoder u_dec (
        .clk      (clk),
        .reset    (reset),
        .m_adr_i  (m_adr),
        .m_stb_i  (m_stb),
        .m_cyc_i  (m_cyc),
        .m_dat_o  (m_dat_r),
        .m_ack_o  (m_ack),
        .s0_stb_o (s0_stb),
        .s0_cyc_o (s0_cyc),
        .s0_dat_i (s0_dat),
        .s0_ack_i (s0_ack),
        .s1_stb_o (s1_stb),
        .s1_cyc_o (s1_cyc),
        .s1_dat_i (s1_dat),
        .s1_ack_i (s1_ack)
    );

    copy_sum u_sum (
        .clk   (clk),
        .reset (reset),
        .clr_i (sum_clr),
        .add_i (sum_add),
        .dat_i (sum_dat),
        .sum_o (sum)
    );

    // lower address bits index inside each slave
    wb_ram_slave u_ram0 (
        .clk   (clk),
        .reset (reset),
        .dat_i (m_dat_w),
        .adr_i (m_adr[RAM_AW-1:0]),
        .tag_i (m_tag),
        .stb_i (s0_stb),
        .cyc_i (s0_cyc),
        .we_i  (m_we),
        .dat_o (s0_dat),
        .ack_o (s0_ack),
        .err_o (),
        .rty_o ()
    );

    wb_ram_slave u_ram1 (
        .clk   (clk),
        .reset (reset),
        .dat_i (m_dat_w),
        .adr_i (m_adr[RAM_AW-1:0]),
        .tag_i (m_tag),
        .stb_i (s1_stb),
        .cyc_i (s1_cyc),
        .we_i  (m_we),
        .dat_o (s1_dat),
        .ack_o (s1_ack),
        .err_o (),
        .rty_o ()
    );

endmodule

//--- hw/copy_ctrl.sv
`timescale 1ns/1ps

module copy_ctrl (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           cmd_valid_i,
    input  wb_copy_pkg::copy_op_e          cmd_op_i,
    input  logic [wb_copy_pkg::ADDR_W-1:0] cmd_src_i,
    input  logic [wb_copy_pkg::ADDR_W-1:0] cmd_dst_i,
    input  logic [wb_copy_pkg::LEN_W-1:0]  cmd_len_i,
    input  logic [wb_copy_pkg::DATA_W-1:0] cmd_data_i,
    output logic                           busy_o,
    output logic                           done_o,
    output logic [wb_copy_pkg::DATA_W-1:0] rdata_o,
    output logic [wb_copy_pkg::ADDR_W-1:0] m_adr_o,
    output logic [wb_copy_pkg::DATA_W-1:0] m_dat_o,
    output logic                           m_we_o,
    output logic                           m_stb_o,
    output logic                           m_cyc_o,
    output logic [wb_copy_pkg::TAG_W-1:0]  m_tag_o,
    input  logic [wb_copy_pkg::DATA_W-1:0] m_dat_i,
    input  logic                           m_ack_i,
    output logic                           sum_clr_o,
    output logic                           sum_add_o,
    output logic [wb_copy_pkg::DATA_W-1:0] sum_dat_o,
    input  logic [wb_copy_pkg::DATA_W-1:0] sum_i
);
    import wb_copy_pkg::*;

    ctrl_state_e       state_q;
    // latched command
    copy_op_e          op_q;
    logic [ADDR_W-1:0] src_q;
    logic [ADDR_W-1:0] dst_q;
    logic [LEN_W-1:0]  len_q;
    logic [DATA_W-1:0] data_q;
    // word index inside the block
    logic [LEN_W-1:0]  cnt_q;
    // word from the last classic read
    logic [DATA_W-1:0] rd_word_q;
    logic              accept;
    logic              last_word;
    logic              is_block;

    assign accept    = (state_q == S_IDLE) && cmd_valid_i;
    assign last_word = (cnt_q == len_q - LEN_W'(1));
    assign is_block  = (cmd_op_i == OP_COPY) || (cmd_op_i == OP_FILL);

    // sum restarts in the accept cycle, before the first block write
    assign sum_clr_o = accept && is_block;

    // every write of COPY or FILL feeds the running sum
    assign sum_add_o = m_ack_i && ((state_q == S_FILL) || (state_q == S_WR && op_q == OP_COPY));
    assign sum_dat_o = m_dat_o;

    // bus drive, decoded from state
    always_comb begin
        m_adr_o = dst_q + cnt_q;
        m_dat_o = data_q;
        m_we_o  = 1'b0;
        m_stb_o = 1'b0;
        m_tag_o = TAG_CLASSIC;
        unique case (state_q)
            S_RD, S_RD_WAIT: begin
                m_adr_o = src_q + cnt_q;
                m_stb_o = 1'b1;
            end
            S_WR, S_WR_WAIT: begin
                m_we_o  = 1'b1;
                m_stb_o = 1'b1;
                // copy writes the held read word as a burst cycle
                if (op_q == OP_COPY) begin
                    m_dat_o = rd_word_q;
                    m_tag_o = TAG_BURST;
                end
            end
            S_FILL: begin
                m_we_o  = 1'b1;
                m_stb_o = 1'b1;
                m_tag_o = TAG_BURST;
            end
            default: begin
                m_stb_o = 1'b0;
            end
        endcase
        m_cyc_o = m_stb_o;
    end

    // operands and read data, no reset needed
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q   <= cmd_op_i;
            src_q  <= cmd_src_i;
            dst_q  <= cmd_dst_i;
            len_q  <= cmd_len_i;
            data_q <= cmd_data_i;
        end
        if (state_q == S_RD_WAIT && m_ack_i) begin
            rd_word_q <= m_dat_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= S_IDLE;
            busy_o  <= 1'b0;
            done_o  <= 1'b0;
            rdata_o <= '0;
            cnt_q   <= '0;
        end else begin
            done_o <= 1'b0;
            unique case (state_q)
                S_IDLE: begin
                    if (cmd_valid_i) begin
                        busy_o <= 1'b1;
                        cnt_q  <= '0;
                        unique case (cmd_op_i)
                            OP_WRITE: state_q <= S_WR;
                            OP_FILL:  state_q <= S_FILL;
                            default:  state_q <= S_RD;
                        endcase
                    end
                end
                // classic read, ack cannot come in the first cycle
                S_RD: state_q <= S_RD_WAIT;
                S_RD_WAIT: begin
                    if (m_ack_i) begin
                        if (op_q == OP_COPY) begin
                            state_q <= S_WR;
                        end else begin
                            state_q <= S_DONE;
                        end
                    end
                end
                S_WR: begin
                    if (op_q != OP_COPY) begin
                        // single write waits for the classic ack
                        state_q <= S_WR_WAIT;
                    end else if (m_ack_i) begin
                        if (last_word) begin
                            state_q <= S_DONE;
                        end else begin
                            cnt_q   <= cnt_q + LEN_W'(1);
                            state_q <= S_RD;
                        end
                    end
                end
                S_WR_WAIT: begin
                    if (m_ack_i) begin
                        state_q <= S_DONE;
                    end
                end
                // one burst write per cycle
                S_FILL: begin
                    if (m_ack_i) begin
                        if (last_word) begin
                            state_q <= S_DONE;
                        end else begin
                            cnt_q <= cnt_q + LEN_W'(1);
                        end
                    end
                end
                S_DONE: begin
                    // sum_i already holds the last add here
                    if (op_q == OP_READ) begin
                        rdata_o <= rd_word_q;
                    end else if (op_q != OP_WRITE) begin
                        rdata_o <= sum_i;
                    end
                    done_o  <= 1'b1;
                    busy_o  <= 1'b0;
                    state_q <= S_IDLE;
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

endmodule

//--- hw/copy_sum.sv
`timescale 1ns/1ps

module copy_sum (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           clr_i,
    input  logic                           add_i,
    input  logic [wb_copy_pkg::DATA_W-1:0] dat_i,
    output logic [wb_copy_pkg::DATA_W-1:0] sum_o
);
    import wb_copy_pkg::*;

    // running total, wraps modulo 2^32
    logic [DATA_W-1:0] acc_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            acc_q <= '0;
        end else if (clr_i) begin
            // new block command starts from zero
            acc_q <= '0;
        end else if (add_i) begin
            acc_q <= acc_q + dat_i;
        end
    end

    assign sum_o = acc_q;

endmodule

//--- hw/wb_decoder.sv
`timescale 1ns/1ps

module wb_decoder (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [wb_copy_pkg::ADDR_W-1:0] m_adr_i,
    input  logic                           m_stb_i,
    input  logic                           m_cyc_i,
    output logic [wb_copy_pkg::DATA_W-1:0] m_dat_o,
    output logic                           m_ack_o,
    output logic                           s0_stb_o,
    output logic                           s0_cyc_o,
    input  logic [wb_copy_pkg::DATA_W-1:0] s0_dat_i,
    input  logic                           s0_ack_i,
    output logic                           s1_stb_o,
    output logic                           s1_cyc_o,
    input  logic [wb_copy_pkg::DATA_W-1:0] s1_dat_i,
    input  logic                           s1_ack_i
);
    import wb_copy_pkg::*;

    // live slave select from address msb
    logic sel;
    // select of the last strobed access
    logic sel_q;

    assign sel = m_adr_i[ADDR_W-1];

    // only the addressed slave sees the cycle
    assign s0_stb_o = m_stb_i & ~sel;
    assign s0_cyc_o = m_cyc_i & ~sel;
    assign s1_stb_o = m_stb_i & sel;
    assign s1_cyc_o = m_cyc_i & sel;

    // read data trails the address by a cycle in burst mode
    // so the data mux follows the select of the previous access
    always_ff @(posedge clk) begin
        if (reset) begin
            sel_q <= 1'b0;
        end else if (m_stb_i && m_cyc_i) begin
            sel_q <= sel;
        end
    end

    assign m_dat_o = sel_q ? s1_dat_i : s0_dat_i;

    // ack is in the same cycle as the address
    assign m_ack_o = sel ? s1_ack_i : s0_ack_i;

endmodule

//--- hw/wb_ram_slave.sv
`timescale 1ns/1ps

module wb_ram_slave (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [wb_copy_pkg::DATA_W-1:0] dat_i,
    input  logic [wb_copy_pkg::RAM_AW-1:0] adr_i,
    input  logic [wb_copy_pkg::TAG_W-1:0]  tag_i,
    input  logic                           stb_i,
    input  logic                           cyc_i,
    input  logic                           we_i,
    output logic [wb_copy_pkg::DATA_W-1:0] dat_o,
    output logic                           ack_o,
    output logic                           err_o,
    output logic                           rty_o
);
    import wb_copy_pkg::*;

    // strobe only counts inside an open cycle
    logic req;
    // memory write enable
    logic ram_we;
    // classic acknowledge, registered
    logic ack_classic_q;
    logic ack_classic_d;
    // burst acknowledge, follows strobe directly
    logic ack_burst;

    assign req    = stb_i & cyc_i;
    assign ram_we = req & we_i;

    // burst: master registers this ack itself and takes read data a cycle later
    assign ack_burst = req;

    // classic ack: one cycle after stb, never two cycles in a row
    assign ack_classic_d = req & ~ack_o;

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_classic_q <= 1'b0;
        end else begin
            ack_classic_q <= ack_classic_d;
        end
    end

    // tag picks which ack the master sees
    assign ack_o = (tag_i == TAG_CLASSIC) ? ack_classic_q : ack_burst;

    // no error or retry responses
    assign err_o = 1'b0;
    assign rty_o = 1'b0;

    sp_ram u_ram (
        .clk    (clk),
        .we_i   (ram_we),
        .addr_i (adr_i),
        .data_i (dat_i),
        .q_o    (dat_o)
    );

endmodule

//--- hw/sp_ram.sv
`timescale 1ns/1ps

module sp_ram (
    input  logic                           clk,
    input  logic                           we_i,
    input  logic [wb_copy_pkg::RAM_AW-1:0] addr_i,
    input  logic [wb_copy_pkg::DATA_W-1:0] data_i,
    output logic [wb_copy_pkg::DATA_W-1:0] q_o
);
    import wb_copy_pkg::*;

    // storage array, no reset on contents
    logic [DATA_W-1:0] mem [0:2**RAM_AW-1];

    // read address, captured every clock
    logic [RAM_AW-1:0] addr_q;

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= data_i;
        end
        addr_q <= addr_i;
    end

    // read after the edge, so a write to the same word shows new data
    assign q_o = mem[addr_q];

endmodule

//--- hw/wb_copy_pkg.sv
package wb_copy_pkg;

    // bus and memory word width
    localparam int DATA_W = 32;

    // bus word address, msb picks the slave
    localparam int ADDR_W = 9;

    // word address inside one ram slave, 256 words
    localparam int RAM_AW = 8;

    // block length, 1 to 256 words
    localparam int LEN_W = 9;

    // cycle type tag carried next to the address
    localparam int TAG_W = 3;

    // classic single cycle, ack one cycle after stb
    localparam logic [TAG_W-1:0] TAG_CLASSIC = 3'b000;
    // incrementing burst, ack comes with stb
    localparam logic [TAG_W-1:0] TAG_BURST = 3'b010;

    // command opcodes
    typedef enum logic [1:0] {
        OP_WRITE = 2'd0,
        OP_READ  = 2'd1,
        OP_COPY  = 2'd2,
        OP_FILL  = 2'd3
    } copy_op_e;

    // controller states
    typedef enum logic [2:0] {
        S_IDLE,
        S_RD,
        S_RD_WAIT,
        S_WR,
        S_WR_WAIT,
        S_FILL,
        S_DONE
    } ctrl_state_e;

endpackage
